/* bmuPkg.sv */
// shared widths, encodings and control words for the bit-manipulation decoder
// import with bmuPkg::* in the module header of any block that needs them
`default_nettype none

package bmuPkg;

  ////////////////////
  // instruction fields
  ////////////////////
  localparam int InstrW  = 32;             // rv32 instruction word
  localparam int OpW     = 7;              // major opcode
  localparam int Funct3W = 3;
  localparam int Funct7W = 7;
  localparam int RegW    = 5;              // register specifier, also rs2 sub-op

  ////////////////////
  // encodings
  ////////////////////

  // only the two major opcodes that carry bitmanip ops on rv32
  typedef enum logic [OpW-1:0] {
    OpReg = 7'b0110011,                    // r-type integer
    OpImm = 7'b0010011                     // i-type integer
  } opcodeT;

  // alu select driven by the bmu, otherwise funct3 passes through
  typedef enum logic [2:0] {
    AluAdd   = 3'b000,                     // also sh*add base add
    AluShift = 3'b001,                     // shifts and rotates
    AluXor   = 3'b100,                     // binv, xnor
    AluExt   = 3'b101,                     // bext
    AluOr    = 3'b110,                     // bset, orn
    AluAnd   = 3'b111                      // bclr, andn
  } aluSelT;

  // functional unit behind the alu result mux
  typedef enum logic [3:0] {
    UnitNone = 4'b0000,                    // plain alu path, base shifts
    UnitAlu  = 4'b0001,                    // zba, zbs, rotates, inverted logic
    UnitZbb  = 4'b0010,                    // count, ext, rev, min/max
    UnitZbc  = 4'b0011                     // carry-less multiply
  } unitSelT;

  // result mux inside zbb; zbc reuses count for clmul/clmulh, ext for clmulr
  typedef enum logic [3:0] {
    ZbbCount  = 4'b0000,
    ZbbExt    = 4'b0001,
    ZbbRev    = 4'b0010,                   // orc.b, rev8
    ZbbMin    = 4'b0011,
    ZbbMaxRot = 4'b0111                    // max, rotates, andn/orn/xnor
  } zbbSelT;

  ////////////////////
  // control words
  ////////////////////

  // one decoder result, all zero when nothing matched
  typedef struct packed {
    aluSelT  aluSel;
    unitSelT unitSel;
    zbbSelT  zbbSel;
    logic    regWrite;                     // writes rd
    logic    srcBImm;                      // b operand from immediate
    logic    aluOp;                        // bmu owns alu select
    logic    subArith;                     // invert b / compare
    logic    rotate;
    logic    mask;                         // single-bit zbs mask
    logic    preShift;                     // sh1add..sh3add
  } bmuDecT;

  // what execute still needs once the instruction leaves decode
  typedef struct packed {
    unitSelT    unitSel;
    zbbSelT     zbbSel;
    logic       regWrite;
    logic [2:0] aluControl;                // {rotate, mask, preShift}
    logic       active;                    // legal bmu op in flight
  } bmuExT;

endpackage

`default_nettype wire

/* bmuDecodeShift.sv */
// decode of zba shift-adds, zbs single-bit ops and the base shifts
// combinational, returns a zero word when the encoding is not its own
`timescale 1ns/1ns
`default_nettype none

module bmuDecodeShift import bmuPkg::*; (
  input  opcodeT             opD,          // major opcode
  input  logic [Funct7W-1:0] funct7D,
  input  logic [Funct3W-1:0] funct3D,
  output logic               hit,          // encoding belongs here
  output bmuDecT             dec
);

  logic isImm;                             // i-type form

  assign isImm = (opD == OpImm);

  always_comb begin
    hit = 1'b1;
    dec = '0;                              // AluAdd, UnitNone by default
    case ({opD, funct7D, funct3D})
      ////////////////////
      // zba
      ////////////////////
      {OpReg, 7'b0010000, 3'b010},         // sh1add
      {OpReg, 7'b0010000, 3'b100},         // sh2add
      {OpReg, 7'b0010000, 3'b110}: begin   // sh3add
        dec.unitSel  = UnitAlu;
        dec.preShift = 1'b1;               // shift amount from funct3 in alu
      end
      ////////////////////
      // zbs, reg and imm
      ////////////////////
      {OpReg, 7'b0100100, 3'b001},
      {OpImm, 7'b0100100, 3'b001}: begin   // bclr, bclri
        dec.aluSel   = AluAnd;
        dec.unitSel  = UnitAlu;
        dec.subArith = 1'b1;               // and with inverted mask
        dec.mask     = 1'b1;
      end
      {OpReg, 7'b0100100, 3'b101},
      {OpImm, 7'b0100100, 3'b101}: begin   // bext, bexti
        dec.aluSel  = AluExt;
        dec.unitSel = UnitAlu;
        dec.mask    = 1'b1;
      end
      {OpReg, 7'b0110100, 3'b001},
      {OpImm, 7'b0110100, 3'b001}: begin   // binv, binvi
        dec.aluSel  = AluXor;
        dec.unitSel = UnitAlu;
        dec.mask    = 1'b1;
      end
      {OpReg, 7'b0010100, 3'b001},
      {OpImm, 7'b0010100, 3'b001}: begin   // bset, bseti
        dec.aluSel  = AluOr;
        dec.unitSel = UnitAlu;
        dec.mask    = 1'b1;
      end
      // base shifts run through the bmu shifter
      {OpReg, 7'b0000000, 3'b001}, {OpImm, 7'b0000000, 3'b001},    // sll, slli
      {OpReg, 7'b0000000, 3'b101}, {OpImm, 7'b0000000, 3'b101},    // srl, srli
      {OpReg, 7'b0100000, 3'b101}, {OpImm, 7'b0100000, 3'b101}:    // sra, srai
        dec.aluSel = AluShift;
      default: hit = 1'b0;
    endcase
    if (!hit) begin
      dec = '0;
    end else begin
      dec.regWrite = 1'b1;
      dec.aluOp    = 1'b1;
      dec.srcBImm  = isImm;                // shamt / bit index from imm
    end
  end

endmodule

`default_nettype wire

/* bmuDecodeLogic.sv */
// decode of zbb and zbc, incl. the unary ops selected by the rs2 field
// combinational, returns a zero word on reserved rs2 codes or foreign encodings
`timescale 1ns/1ns
`default_nettype none

module bmuDecodeLogic import bmuPkg::*; (
  input  opcodeT             opD,
  input  logic [Funct7W-1:0] funct7D,
  input  logic [Funct3W-1:0] funct3D,
  input  logic [RegW-1:0]    rs2D,         // sub-op for unary forms
  output logic               hit,
  output bmuDecT             dec
);

  always_comb begin
    hit = 1'b1;
    dec = '0;
    case ({opD, funct7D, funct3D})
      ////////////////////
      // zbb unary, rs2 picks the op
      ////////////////////
      {OpImm, 7'b0110000, 3'b001}: begin
        dec.unitSel = UnitZbb;
        if (rs2D[RegW-1:1] == 4'b0010) begin
          dec.zbbSel = ZbbExt;             // sext.b / sext.h
        end else if (rs2D[RegW-1:2] == 3'b000 && rs2D[1:0] != 2'b11) begin
          dec.zbbSel = ZbbCount;           // clz, ctz, cpop
        end else begin
          hit = 1'b0;                      // reserved count code
        end
      end
      {OpImm, 7'b0010100, 3'b101}: begin   // orc.b
        dec.unitSel = UnitZbb;
        dec.zbbSel  = ZbbRev;
        hit         = (rs2D == 5'b00111);
      end
      {OpImm, 7'b0110100, 3'b101}: begin   // rev8, rv32 form only
        dec.unitSel = UnitZbb;
        dec.zbbSel  = ZbbRev;
        hit         = (rs2D == 5'b11000);
      end
      {OpReg, 7'b0000100, 3'b100}: begin   // zext.h
        dec.unitSel = UnitZbb;
        dec.zbbSel  = ZbbExt;
        dec.srcBImm = 1'b1;                // rs2 field is zero, b from imm path
      end
      ////////////////////
      // compare, rotate, inverted logic
      ////////////////////
      {OpReg, 7'b0000101, 3'b110}, {OpReg, 7'b0000101, 3'b111},    // max, maxu
      {OpReg, 7'b0000101, 3'b100}, {OpReg, 7'b0000101, 3'b101}: begin  // min, minu
        dec.unitSel  = UnitZbb;
        dec.zbbSel   = funct3D[1] ? ZbbMaxRot : ZbbMin;
        dec.subArith = 1'b1;               // subtract for the compare
      end
      {OpReg, 7'b0110000, 3'b001},         // rol
      {OpReg, 7'b0110000, 3'b101},         // ror
      {OpImm, 7'b0110000, 3'b101}: begin   // rori
        dec.aluSel  = AluShift;
        dec.unitSel = (opD == OpImm) ? UnitNone : UnitAlu;
        dec.zbbSel  = ZbbMaxRot;
        dec.rotate  = 1'b1;
      end
      {OpReg, 7'b0100000, 3'b111},         // andn
      {OpReg, 7'b0100000, 3'b110},         // orn
      {OpReg, 7'b0100000, 3'b100}: begin   // xnor
        dec.aluSel   = aluSelT'({1'b1, funct3D[1:0]});  // and / or / xor
        dec.unitSel  = UnitAlu;
        dec.zbbSel   = ZbbMaxRot;
        dec.subArith = 1'b1;               // invert b
      end
      ////////////////////
      // zbc
      ////////////////////
      {OpReg, 7'b0000101, 3'b001},         // clmul
      {OpReg, 7'b0000101, 3'b011}: dec.unitSel = UnitZbc;  // clmulh
      {OpReg, 7'b0000101, 3'b010}: begin   // clmulr
        dec.unitSel = UnitZbc;
        dec.zbbSel  = ZbbExt;              // reversed result
      end
      default: hit = 1'b0;
    endcase
    if (!hit) begin
      dec = '0;
    end else begin
      dec.regWrite = 1'b1;
      dec.aluOp    = 1'b1;
      if (opD == OpImm) dec.srcBImm = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* bmuCtrlDecode.sv */
// decode-stage front end: field split, both sub-decoders, merge and alu select
// illegal means neither sub-decoder claimed the instruction
`timescale 1ns/1ns
`default_nettype none

module bmuCtrlDecode import bmuPkg::*; (
  input  logic [InstrW-1:0] instrD,
  input  logic              aluOpD,        // base alu op from main decoder
  output bmuDecT            decD,
  output logic              illegalD,
  output logic [2:0]        aluSelectD
);

  opcodeT             opD;
  logic [Funct3W-1:0] funct3D;
  logic [Funct7W-1:0] funct7D;
  logic [RegW-1:0]    rs2D;
  logic               shiftHit, logicHit;
  bmuDecT             shiftDec, logicDec;

  ////////////////////
  // fields
  ////////////////////
  assign opD     = opcodeT'(instrD[6:0]); // other opcodes simply never match
  assign funct3D = instrD[14:12];
  assign funct7D = instrD[31:25];
  assign rs2D    = instrD[24:20];

  bmuDecodeShift i_bmuDecodeShift (
    .opD     (opD),
    .funct7D (funct7D),
    .funct3D (funct3D),
    .hit     (shiftHit),
    .dec     (shiftDec)
  );

  bmuDecodeLogic i_bmuDecodeLogic (
    .opD     (opD),
    .funct7D (funct7D),
    .funct3D (funct3D),
    .rs2D    (rs2D),
    .hit     (logicHit),
    .dec     (logicDec)
  );

  // a miss returns zeros, so the logic word covers both the hit and the none case
  assign decD     = shiftHit ? shiftDec : logicDec;
  assign illegalD = ~(shiftHit | logicHit);

  // bmu code, else funct3 for base alu ops, else add for address calc
  assign aluSelectD = decD.aluOp ? decD.aluSel : (aluOpD ? funct3D : AluAdd);

  // encoding spaces of the two tables are disjoint
  always_comb begin
    assert final (!(shiftHit && logicHit))
      else $error("bmu sub-decoders both claim instr %h", instrD);
  end

endmodule

`default_nettype wire

/* bmuCtrlPipe.sv */
// execute-stage copy of the bmu control word
// stall holds the word and wins over flush, flush inserts a bubble
`timescale 1ns/1ns
`default_nettype none

module bmuCtrlPipe import bmuPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   stallE,
  input  logic   flushE,
  input  bmuDecT decD,
  input  logic   illegalD,
  output bmuExT  exE
);

  bmuExT exD;                              // word as it enters execute

  assign exD.unitSel    = decD.unitSel;
  assign exD.zbbSel     = decD.zbbSel;
  assign exD.regWrite   = decD.regWrite;
  assign exD.aluControl = {decD.rotate, decD.mask, decD.preShift};
  assign exD.active     = ~illegalD;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exE <= '0;                           // no bmu op, no write
    end else if (!stallE) begin
      if (flushE) exE <= '0;               // bubble
      else        exE <= exD;
    end
  end

  ////////////////////
  // checks
  ////////////////////
  assert property (@(posedge clk) disable iff (!rstN) stallE |=> $stable(exE))
    else $error("bmu execute word changed under stall");

  assert property (@(posedge clk) disable iff (!rstN) (flushE && !stallE) |=> !exE.active)
    else $error("bmu op still active after flush");

endmodule

`default_nettype wire

/* bmuCtrl.sv */
// bit-manipulation control top: decode-stage decoder plus execute register
// decode outputs are combinational, exE follows one edge later unless stalled
`timescale 1ns/1ns
`default_nettype none

module bmuCtrl import bmuPkg::*; (
  input  logic              clk,
  input  logic              rstN,
  input  logic [InstrW-1:0] instrD,
  input  logic              aluOpD,
  input  logic              stallE,
  input  logic              flushE,
  output bmuDecT            decD,
  output logic              illegalD,
  output logic [2:0]        aluSelectD,
  output bmuExT             exE
);

  bmuCtrlDecode i_bmuCtrlDecode (
    .instrD     (instrD),
    .aluOpD     (aluOpD),
    .decD       (decD),
    .illegalD   (illegalD),
    .aluSelectD (aluSelectD)
  );

  bmuCtrlPipe i_bmuCtrlPipe (
    .clk      (clk),
    .rstN     (rstN),
    .stallE   (stallE),
    .flushE   (flushE),
    .decD     (decD),
    .illegalD (illegalD),
    .exE      (exE)
  );

endmodule

`default_nettype wire

/* tbBmuCtrl.sv */
// testbench for the bmu control block
// reads bmuCases.txt, checks decode outputs per case, then the execute word
// under clean, stalled and flushed cycles
`timescale 1ns/1ns
`default_nettype none

module tbBmuCtrl import bmuPkg::*; ();

  logic              clk;
  logic              rstN;
  logic [InstrW-1:0] instrD;
  logic              aluOpD;
  logic              stallE;
  logic              flushE;
  bmuDecT            decD;
  logic              illegalD;
  logic [2:0]        aluSelectD;
  bmuExT             exE;

  // case table, filled from the file
  string             caseName[$];
  logic [InstrW-1:0] caseInstr[$];
  logic              caseAluOp[$];
  bmuDecT            caseDec[$];
  logic              caseIll[$];
  logic [2:0]        caseSel[$];

  int     checkErrs = 0;
  int     otherErrs = 0;
  int     cycleCount = 0;
  int     cycleLimit = 50;                 // raised once the cases are known
  bmuExT  expEx;                           // model of the execute register
  bmuExT  lastWord;                        // word offered at the last edge
  logic   lastStall;
  logic   lastFlush;

  bmuCtrl i_bmuCtrl (
    .clk        (clk),
    .rstN       (rstN),
    .instrD     (instrD),
    .aluOpD     (aluOpD),
    .stallE     (stallE),
    .flushE     (flushE),
    .decD       (decD),
    .illegalD   (illegalD),
    .aluSelectD (aluSelectD),
    .exE        (exE)
  );

  always #4 clk = ~clk;                    // 8 ns period

  ////////////////////
  // helpers
  ////////////////////
  task automatic checkVal(input string name, input string field,
                          input logic [31:0] expVal, input logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", name, field, expVal, actVal);
      checkErrs++;
    end
  endtask

  // execute word as the stage should build it from a decode result
  function automatic bmuExT buildExWord(input bmuDecT d, input logic ill);
    bmuExT w;
    w.unitSel    = d.unitSel;
    w.zbbSel     = d.zbbSel;
    w.regWrite   = d.regWrite;
    w.aluControl = {d.rotate, d.mask, d.preShift};
    w.active     = !ill;                   // only legal ops go live
    return w;
  endfunction

  task automatic loadCases(output bit ok);
    int                fd;
    string             tag;
    string             line;
    logic [InstrW-1:0] instrV;
    logic              aluV;
    logic [17:0]       decV;
    logic              illV;
    logic [2:0]        selV;
    ok = 1'b0;
    fd = $fopen("bmuCases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        if ($fscanf(fd, "%s", tag) == 1) begin
          if (tag[0] == "#") begin
            void'($fgets(line, fd));       // column notes
          end else if ($fscanf(fd, "%h %b %h %b %h", instrV, aluV, decV, illV, selV) == 5) begin
            caseName.push_back(tag);
            caseInstr.push_back(instrV);
            caseAluOp.push_back(aluV);
            caseDec.push_back(bmuDecT'(decV));
            caseIll.push_back(illV);
            caseSel.push_back(selV);
          end
        end
      end
      $fclose(fd);
      ok = (caseName.size() > 0);
    end
  endtask

  // one pass over all cases; stall/flush random only when asked
  task automatic runPass(input bit randomCtl);
    bit stallV;
    bit flushV;
    for (int i = 0; i < caseName.size(); i++) begin
      stallV = randomCtl && ($urandom % 3 == 0);
      flushV = randomCtl && ($urandom % 4 == 0);
      @(posedge clk);
      instrD <= caseInstr[i];
      aluOpD <= caseAluOp[i];
      stallE <= stallV;
      flushE <= flushV;
      // this edge used the controls and word driven one edge earlier
      if (!lastStall) expEx = lastFlush ? '0 : lastWord;
      lastStall = stallV;
      lastFlush = flushV;
      lastWord  = buildExWord(caseDec[i], caseIll[i]);
      @(negedge clk);                      // decode is settled mid-cycle
      checkVal(caseName[i], "decD", 32'(caseDec[i]), 32'(decD));
      checkVal(caseName[i], "illegalD", 32'(caseIll[i]), 32'(illegalD));
      checkVal(caseName[i], "aluSelectD", 32'(caseSel[i]), 32'(aluSelectD));
      checkVal(caseName[i], "exE", 32'(expEx), 32'(exE));
    end
  endtask

  task automatic finishRun();
    $display("check errors: %0d, other errors: %0d", checkErrs, otherErrs);
    if (checkErrs == 0 && otherErrs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  ////////////////////
  // watchdog
  ////////////////////
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout after %0d cycles, run did not complete", cycleCount);
      otherErrs++;
      finishRun();
    end
  end

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    bit ok;
    void'($urandom(86));
    clk       = 1'b0;
    rstN      = 1'b0;
    instrD    = '0;                        // no op until the cases are in
    aluOpD    = 1'b0;
    stallE    = 1'b0;
    flushE    = 1'b0;
    expEx     = '0;
    lastWord  = '0;
    lastStall = 1'b0;
    lastFlush = 1'b0;
    loadCases(ok);
    if (!ok) begin
      $display("cases file bmuCases.txt is missing or holds no cases");
      otherErrs++;
    end else begin
      cycleLimit = 4 * caseName.size() + 50;
      @(posedge clk);
      instrD   <= caseInstr[0];            // real op offered while in reset
      aluOpD   <= caseAluOp[0];
      lastWord  = buildExWord(caseDec[0], caseIll[0]);
      @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      checkVal("reset", "exE", 32'd0, 32'(exE));
      runPass(1'b0);                       // clean pipeline
      runPass(1'b1);                       // random stall and flush
    end
    finishRun();
  end

endmodule

`default_nettype wire

/* bmuCases.txt */
# name instr(hex) aluOpD decD(hex, 18-bit bmuDecT) illegalD aluSelectD(hex)
# decD msb first: aluSel[17:15] unitSel[14:11] zbbSel[10:7] regWrite srcBImm aluOp subArith rotate mask preShift
sh1add      2030A133 0 00851 0 0
sh2add      2030C133 0 00851 0 0
sh3add      2030E133 1 00851 0 0
bclr        48309133 0 3885A 0 7
bclri       48509113 0 3887A 0 7
bext        4830D133 0 28852 0 5
bexti       4850D113 0 28872 0 5
binv        68309133 0 20852 0 4
binvi       68509113 0 20872 0 4
bset        28309133 0 30852 0 6
bseti       28509113 0 30872 0 6
sll         00309133 1 08050 0 1
slli        00509113 1 08070 0 1
srl         0030D133 1 08050 0 1
srli        0050D113 1 08070 0 1
sra         4030D133 1 08050 0 1
srai        4050D113 1 08070 0 1
clz         60009113 0 01070 0 0
ctz         60109113 0 01070 0 0
cpop        60209113 0 01070 0 0
sextB       60409113 0 010F0 0 0
sextH       60509113 0 010F0 0 0
orcB        2870D113 0 01170 0 0
rev8        6980D113 0 01170 0 0
zextH       0800C133 0 010F0 0 0
max         0A30E133 0 013D8 0 0
maxu        0A30F133 1 013D8 0 0
min         0A30C133 0 011D8 0 0
minu        0A30D133 0 011D8 0 0
rol         60309133 0 08BD4 0 1
ror         6030D133 0 08BD4 0 1
rori        6050D113 0 083F4 0 1
andn        4030F133 0 38BD8 0 7
orn         4030E133 0 30BD8 0 6
xnor        4030C133 1 20BD8 0 4
clmul       0A309133 0 01850 0 0
clmulh      0A30B133 0 01850 0 0
clmulr      0A30A133 0 018D0 0 0
countRsv3   60309113 1 00000 1 1
countRsv6   60609113 0 00000 1 0
orcBRsv     2860D113 0 00000 1 0
rev8Rsv     6870D113 0 00000 1 0
sh1addUw    2030A13B 0 00000 1 0
xperm8      2830C133 0 00000 1 0
xorAlu      0030C133 1 00000 1 4
orAlu       0030E133 1 00000 1 6
addiNoAlu   00508113 0 00000 1 0
lwNoAlu     0040A103 0 00000 1 0
bsetAluOp   28309133 1 30852 0 6

/* project.f */
bmuPkg.sv
bmuDecodeShift.sv
bmuDecodeLogic.sv
bmuCtrlDecode.sv
bmuCtrlPipe.sv
bmuCtrl.sv
tbBmuCtrl.sv

/* Makefile */
TOP = tbBmuCtrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
